//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int nr_regs = 16;
    localparam int queue_depth = 4;
    localparam int credit_width = $clog2(queue_depth + 1);  // counts 0 .. queue_depth
    localparam int qptr_width = $clog2(queue_depth);

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    localparam logic [11:0] csr_mepc = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec = 12'h305;

    localparam logic [xlen-1:0] ecall_cause = 32'd11;  // environment call from m-mode

    localparam logic [31:0] inst_ecall = 32'h0000_0073;
    localparam logic [31:0] inst_mret = 32'h3020_0073;
    localparam logic [31:0] inst_fence_i = 32'h0000_100f;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011,
        op_fence  = 7'b0001111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_eq
    } alu_op_t;

    typedef enum logic [1:0] {
        src1_reg,
        src1_pc,
        src1_zero
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_imm,
        src2_reg,
        src2_csr_set,    // csrrs
        src2_csr_write   // csrrw
    } src2_sel_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } fetch_entry_t;

    // csr_wen bits: 0 mepc, 1 mcause, 2 mstatus, 3 mtvec
    typedef struct packed {
        logic            reg_wen;
        logic [3:0]      rd;
        logic [xlen-1:0] rd_value;
        logic [3:0]      csr_wen;
        logic [xlen-1:0] csr_value;
    } wb_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [3:0]      rd;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] imm;
        alu_op_t         alu_op;
        src1_sel_t       src1_sel;
        src2_sel_t       src2_sel;
        logic            reg_wen;
        logic            mem_wen;
        logic            mem_ren;
        logic            branch;
        logic            invert;
        logic            jump;
        logic [3:0]      csr_wen;
        logic [xlen-1:0] link_value;
        logic            ecall;
        logic            mret;
        logic            fence_i;
        logic [2:0]      funct3;
    } decoded_t;

endpackage

`default_nettype wire

//--- verilog/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     fetch_enable,
    output logic                     imem_req,
    output logic [rv_pkg::xlen-1:0]  imem_addr,
    input  logic [rv_pkg::xlen-1:0]  imem_data,
    output logic                     push_valid,
    output rv_pkg::fetch_entry_t     push_entry,
    input  logic                     credit_return
);
    import rv_pkg::*;

    logic [xlen-1:0]         pc;
    logic [credit_width-1:0] credits;
    logic                    have_credit;

    assign have_credit = (credits != '0);

    // one word per cycle while a queue slot is guaranteed
    assign imem_req = fetch_enable && have_credit;
    assign imem_addr = pc;

    // the accepted word goes straight into the queue this cycle
    assign push_valid = imem_req;
    assign push_entry.pc = pc;
    assign push_entry.inst = imem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (push_valid) begin
            pc <= pc + 32'd4;  // no redirect, strictly sequential
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= credit_width'(queue_depth);
        end else begin
            case ({push_valid, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;  // both or neither, net zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/inst_queue.sv
`default_nettype none

module inst_queue (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 push_valid,
    input  rv_pkg::fetch_entry_t push_entry,
    output logic                 head_valid,
    output rv_pkg::fetch_entry_t head_entry,
    input  logic                 pop,
    output logic                 credit_return
);
    import rv_pkg::*;

    fetch_entry_t            entries [queue_depth];
    logic [qptr_width-1:0]   wr_ptr;
    logic [qptr_width-1:0]   rd_ptr;
    logic [credit_width-1:0] count;

    function automatic logic [qptr_width-1:0] next_ptr(input logic [qptr_width-1:0] ptr);
        if (ptr == qptr_width'(queue_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_entry = entries[rd_ptr];

    // freed slot goes back to fetch in the pop cycle
    assign credit_return = pop;

    // no full check, fetch never pushes without a credit
    always_ff @(posedge clock) begin
        if (push_valid) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [3:0]              rs1_idx,
    input  logic [3:0]              rs2_idx,
    output logic [rv_pkg::xlen-1:0] rs1_value,
    output logic [rv_pkg::xlen-1:0] rs2_value,
    input  logic [11:0]             csr_idx,
    output logic [rv_pkg::xlen-1:0] csr_value,
    input  rv_pkg::wb_t             wb,
    input  logic                    trap_valid,
    input  logic [rv_pkg::xlen-1:0] trap_pc,
    output logic [rv_pkg::xlen-1:0] mepc_out,
    output logic [rv_pkg::xlen-1:0] mtvec_out
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [nr_regs];
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;

    always_ff @(posedge clock) begin
        if (wb.reg_wen) begin
            regs[wb.rd] <= wb.rd_value;  // x0 slot may be written, it is never read out
        end
    end

    assign rs1_value = (rs1_idx == 4'd0) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == 4'd0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            mepc <= '0;
            mcause <= '0;
            mstatus <= '0;
            mtvec <= '0;
        end else begin
            if (trap_valid) begin
                mepc <= trap_pc;  // trap beats writeback
                mcause <= ecall_cause;
            end else begin
                if (wb.csr_wen[0]) mepc <= wb.csr_value;
                if (wb.csr_wen[1]) mcause <= wb.csr_value;
            end
            if (wb.csr_wen[2]) mstatus <= wb.csr_value;
            if (wb.csr_wen[3]) mtvec <= wb.csr_value;
        end
    end

    always_comb begin
        case (csr_idx)
            csr_mepc: csr_value = mepc;
            csr_mcause: csr_value = mcause;
            csr_mstatus: csr_value = mstatus;
            csr_mtvec: csr_value = mtvec;
            default: csr_value = '0;
        endcase
    end

    assign mepc_out = mepc;
    assign mtvec_out = mtvec;

endmodule

`default_nettype wire

//--- verilog/decode_unit.sv
`default_nettype none

module decode_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    head_valid,
    input  rv_pkg::fetch_entry_t    head_entry,
    output logic                    pop,
    output logic [3:0]              rs1_idx,
    output logic [3:0]              rs2_idx,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] rs2_value,
    output logic [11:0]             csr_idx,
    input  logic [rv_pkg::xlen-1:0] csr_value,
    output logic                    trap_valid,
    output logic [rv_pkg::xlen-1:0] trap_pc,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rv_pkg::decoded_t        out_bundle
);
    import rv_pkg::*;

    logic [31:0]     inst;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic            is_csr_op;
    decoded_t        next_bundle;

    // shared by op-imm and op: funct3 picks the op, bit 30 picks sub/sra
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                         input logic allow_sub);
        case (f3)
            3'b000: return (alt && allow_sub) ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign inst = head_entry.inst;
    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1_idx = inst[18:15];  // rv32e, upper index bit unused
    assign rs2_idx = inst[23:20];
    assign csr_idx = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign is_csr_op = (opcode == op_system) && (funct3 == 3'b001 || funct3 == 3'b010);

    // output slot free or draining this cycle
    assign pop = head_valid && (!out_valid || out_ready);

    assign trap_valid = pop && next_bundle.ecall;
    assign trap_pc = head_entry.pc;

    always_comb begin
        next_bundle = '0;
        next_bundle.pc = head_entry.pc;
        next_bundle.rd = inst[10:7];
        next_bundle.rs1_value = rs1_value;
        next_bundle.rs2_value = rs2_value;
        next_bundle.funct3 = funct3;
        next_bundle.alu_op = alu_add;
        next_bundle.src1_sel = src1_reg;
        next_bundle.src2_sel = src2_imm;
        next_bundle.reg_wen = 1'b1;
        case (opcode)
            op_lui: begin
                next_bundle.imm = imm_u;
                next_bundle.src1_sel = src1_zero;
            end
            op_auipc: begin
                next_bundle.imm = imm_u;
                next_bundle.src1_sel = src1_pc;
            end
            op_jal: begin
                next_bundle.imm = imm_j;
                next_bundle.src1_sel = src1_pc;
                next_bundle.jump = 1'b1;
            end
            op_jalr: begin
                next_bundle.imm = imm_i;
                next_bundle.jump = 1'b1;
            end
            op_branch: begin
                next_bundle.imm = imm_b;
                next_bundle.src2_sel = src2_reg;
                next_bundle.branch = 1'b1;
                next_bundle.reg_wen = 1'b0;
                next_bundle.invert = (funct3 == 3'b001 || funct3 == 3'b101 ||
                                      funct3 == 3'b111);  // bne, bge, bgeu
                case (funct3[2:1])
                    2'b00: next_bundle.alu_op = alu_eq;
                    2'b10: next_bundle.alu_op = alu_slt;
                    default: next_bundle.alu_op = alu_sltu;
                endcase
            end
            op_load: begin
                next_bundle.imm = imm_i;
                next_bundle.mem_ren = 1'b1;
            end
            op_store: begin
                next_bundle.imm = imm_s;
                next_bundle.mem_wen = 1'b1;
                next_bundle.reg_wen = 1'b0;
            end
            op_imm: begin
                next_bundle.imm = imm_i;
                next_bundle.alu_op = arith_op(funct3, inst[30], 1'b0);
            end
            op_reg: begin
                next_bundle.src2_sel = src2_reg;
                next_bundle.alu_op = arith_op(funct3, inst[30], 1'b1);
            end
            op_system: begin
                next_bundle.imm = imm_i;
                if (funct3 == 3'b010) begin
                    next_bundle.src2_sel = src2_csr_set;
                    next_bundle.alu_op = alu_or;
                end else if (funct3 == 3'b001) begin
                    next_bundle.src2_sel = src2_csr_write;
                end
            end
            default: begin
            end
        endcase
        next_bundle.csr_wen[0] = is_csr_op && (csr_idx == csr_mepc);
        next_bundle.csr_wen[1] = is_csr_op && (csr_idx == csr_mcause);
        next_bundle.csr_wen[2] = is_csr_op && (csr_idx == csr_mstatus);
        next_bundle.csr_wen[3] = is_csr_op && (csr_idx == csr_mtvec);
        if (next_bundle.jump) begin
            next_bundle.link_value = head_entry.pc + 32'd4;
        end else if (|next_bundle.csr_wen) begin
            next_bundle.link_value = csr_value;  // old csr value goes to rd
        end
        next_bundle.ecall = (inst == inst_ecall);
        next_bundle.mret = (inst == inst_mret);
        next_bundle.fence_i = (inst == inst_fence_i);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            out_bundle <= next_bundle;  // held while stalled
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode_core.sv
`default_nettype none

module decode_core (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_enable,
    output logic                    imem_req,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    input  rv_pkg::wb_t             wb,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rv_pkg::decoded_t        out_bundle,
    output logic [rv_pkg::xlen-1:0] mepc_out,
    output logic [rv_pkg::xlen-1:0] mtvec_out
);
    import rv_pkg::*;

    logic            push_valid;
    fetch_entry_t    push_entry;
    logic            credit_return;
    logic            head_valid;
    fetch_entry_t    head_entry;
    logic            pop;
    logic [3:0]      rs1_idx;
    logic [3:0]      rs2_idx;
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
    logic [11:0]     csr_idx;
    logic [xlen-1:0] csr_value;
    logic            trap_valid;
    logic [xlen-1:0] trap_pc;

    fetch_unit fetch0 (
        .clock(clock), .reset(reset), .fetch_enable(fetch_enable),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_data(imem_data),
        .push_valid(push_valid), .push_entry(push_entry), .credit_return(credit_return)
    );

    inst_queue queue0 (
        .clock(clock), .reset(reset), .push_valid(push_valid), .push_entry(push_entry),
        .head_valid(head_valid), .head_entry(head_entry), .pop(pop),
        .credit_return(credit_return)
    );

    decode_unit decode0 (
        .clock(clock), .reset(reset), .head_valid(head_valid), .head_entry(head_entry),
        .pop(pop), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_value(rs1_value),
        .rs2_value(rs2_value), .csr_idx(csr_idx), .csr_value(csr_value),
        .trap_valid(trap_valid), .trap_pc(trap_pc), .out_valid(out_valid),
        .out_ready(out_ready), .out_bundle(out_bundle)
    );

    reg_file regs0 (
        .clock(clock), .reset(reset), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .csr_idx(csr_idx),
        .csr_value(csr_value), .wb(wb), .trap_valid(trap_valid), .trap_pc(trap_pc),
        .mepc_out(mepc_out), .mtvec_out(mtvec_out)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #2 clock = ~clock;  // period of 4

endmodule

`default_nettype wire

//--- tb/decode_chk.sv
`default_nettype none

// level counts credits in fetch and entries in the queue
module decode_chk (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [rv_pkg::credit_width-1:0] level,
    input  logic                            take,
    input  logic                            give
);
    import rv_pkg::*;

    localparam logic [credit_width-1:0] full_level = credit_width'(queue_depth);

    a_level_bound: assert property (
        @(posedge clock) disable iff (reset) level <= full_level
    ) else $error("level %0d is above the queue depth", level);

    // push without a credit, or pop of an empty queue
    a_no_underflow: assert property (
        @(posedge clock) disable iff (reset) take |-> level != '0
    ) else $error("take while level is zero");

    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset) (give && !take) |-> level < full_level
    ) else $error("give while level is already full");

endmodule

bind fetch_unit decode_chk credit_chk (
    .clock(clock), .reset(reset), .level(credits), .take(push_valid), .give(credit_return)
);

bind inst_queue decode_chk occupancy_chk (
    .clock(clock), .reset(reset), .level(count), .take(pop), .give(push_valid)
);

`default_nettype wire

//--- tb/decode_tb.sv
`default_nettype none

module decode_tb;
    import rv_pkg::*;

    localparam int nr_words = 64;
    localparam int nr_transfers = 64;
    localparam int cycle_limit = nr_transfers * 8 + 300;

    logic            clock;
    logic            reset;
    logic            fetch_enable;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    wb_t             wb;
    logic            out_valid;
    logic            out_ready = 1'b0;
    decoded_t        out_bundle;
    logic [xlen-1:0] mepc_out;
    logic [xlen-1:0] mtvec_out;

    logic [31:0]     imem [nr_words];
    logic [2:0]      branch_f3 [8];
    logic [11:0]     csr_pick [8];
    logic [xlen-1:0] model_regs [nr_regs];
    logic [xlen-1:0] model_mepc;
    logic [xlen-1:0] model_mcause;
    logic [xlen-1:0] model_mstatus;
    logic [xlen-1:0] model_mtvec;
    logic [xlen-1:0] exp_pc;
    decoded_t        exp_bundle;
    decoded_t        last_bundle;
    logic            last_stall;
    logic            transfer;
    logic [31:0]     ready_roll;
    int              transfers;
    int              pushes;
    int              cycles = 0;

    tb_clock clock0 (.clock(clock));

    decode_core dut0 (
        .clock(clock), .reset(reset), .fetch_enable(fetch_enable),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_data(imem_data),
        .wb(wb), .out_valid(out_valid), .out_ready(out_ready), .out_bundle(out_bundle),
        .mepc_out(mepc_out), .mtvec_out(mtvec_out)
    );

    assign imem_data = imem[imem_addr[7:2]];  // wraps after 64 words
    assign transfer = out_valid && out_ready;

    function automatic logic [xlen-1:0] model_csr(input logic [11:0] addr);
        if (addr == csr_mepc) return model_mepc;
        if (addr == csr_mcause) return model_mcause;
        if (addr == csr_mstatus) return model_mstatus;
        if (addr == csr_mtvec) return model_mtvec;
        return '0;
    endfunction

    function automatic alu_op_t ref_alu(input logic [2:0] f3, input logic bit30,
                                        input logic is_reg);
        alu_op_t op;
        op = alu_and;
        if (f3 == 3'd0) op = (is_reg && bit30) ? alu_sub : alu_add;
        if (f3 == 3'd1) op = alu_sll;
        if (f3 == 3'd2) op = alu_slt;
        if (f3 == 3'd3) op = alu_sltu;
        if (f3 == 3'd4) op = alu_xor;
        if (f3 == 3'd5) op = bit30 ? alu_sra : alu_srl;
        if (f3 == 3'd6) op = alu_or;
        return op;
    endfunction

    function automatic decoded_t ref_decode(input logic [xlen-1:0] pc, input logic [31:0] w);
        decoded_t    d;
        opcode_t     op;
        logic [2:0]  f3;
        logic [11:0] csr;
        d = '0;
        op = opcode_t'(w[6:0]);
        f3 = w[14:12];
        csr = w[31:20];
        d.pc = pc;
        d.rd = w[10:7];
        d.funct3 = f3;
        d.rs1_value = (w[18:15] == 4'd0) ? '0 : model_regs[w[18:15]];
        d.rs2_value = (w[23:20] == 4'd0) ? '0 : model_regs[w[23:20]];
        d.alu_op = alu_add;
        d.src1_sel = src1_reg;
        d.src2_sel = src2_imm;
        d.reg_wen = !(op == op_store || op == op_branch);
        case (op)
            op_lui, op_auipc: begin
                d.imm = {w[31:12], 12'h000};
                d.src1_sel = (op == op_lui) ? src1_zero : src1_pc;
            end
            op_jal: begin
                d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                d.src1_sel = src1_pc;
                d.jump = 1'b1;
            end
            op_jalr: begin
                d.imm = 32'($signed(w[31:20]));
                d.jump = 1'b1;
            end
            op_branch: begin
                d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                d.src2_sel = src2_reg;
                d.branch = 1'b1;
                d.invert = f3 inside {3'd1, 3'd5, 3'd7};
                if (f3 inside {3'd0, 3'd1}) d.alu_op = alu_eq;
                else if (f3 inside {3'd4, 3'd5}) d.alu_op = alu_slt;
                else d.alu_op = alu_sltu;
            end
            op_load: begin
                d.imm = 32'($signed(w[31:20]));
                d.mem_ren = 1'b1;
            end
            op_store: begin
                d.imm = 32'($signed({w[31:25], w[11:7]}));
                d.mem_wen = 1'b1;
            end
            op_imm: begin
                d.imm = 32'($signed(w[31:20]));
                d.alu_op = ref_alu(f3, w[30], 1'b0);
            end
            op_reg: begin
                d.src2_sel = src2_reg;
                d.alu_op = ref_alu(f3, w[30], 1'b1);
            end
            op_system: begin
                d.imm = 32'($signed(w[31:20]));
                if (f3 == 3'd1) d.src2_sel = src2_csr_write;
                if (f3 == 3'd2) begin
                    d.src2_sel = src2_csr_set;
                    d.alu_op = alu_or;
                end
                if (f3 == 3'd1 || f3 == 3'd2) begin
                    d.csr_wen = {csr == csr_mtvec, csr == csr_mstatus,
                                 csr == csr_mcause, csr == csr_mepc};
                end
            end
            default: begin
            end
        endcase
        if (d.jump) d.link_value = pc + 32'd4;
        else if (d.csr_wen != 4'd0) d.link_value = model_csr(csr);
        d.ecall = (w == 32'h0000_0073);
        d.mret = (w == 32'h3020_0073);
        d.fence_i = (w == 32'h0000_100f);
        return d;
    endfunction

    function automatic logic [20:0] control_bits(input decoded_t b);
        return {b.alu_op, b.src1_sel, b.src2_sel, b.reg_wen, b.mem_wen, b.mem_ren,
                b.branch, b.invert, b.jump, b.csr_wen, b.ecall, b.mret, b.fence_i};
    endfunction

    task automatic report_mismatch(input string test, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("ERROR %s: expected %0h actual %0h", test, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "check %s failed", test);
    endtask

    task automatic write_reg(input logic [3:0] idx, input logic [xlen-1:0] value);
        @(posedge clock);
        wb <= {1'b1, idx, value, 4'b0000, 32'h0};
    endtask

    task automatic write_csr(input logic [3:0] mask, input logic [xlen-1:0] value);
        @(posedge clock);
        wb <= {1'b0, 4'd0, 32'h0, mask, value};
    endtask

    always_comb exp_bundle = ref_decode(exp_pc, imem[exp_pc[7:2]]);

    // register and csr model, updated at the same edge as the dut
    always @(posedge clock) begin
        if (reset) begin
            model_mepc <= '0;
            model_mcause <= '0;
            model_mstatus <= '0;
            model_mtvec <= '0;
        end else begin
            if (wb.reg_wen) model_regs[wb.rd] <= wb.rd_value;
            if (transfer && exp_bundle.ecall) begin
                model_mepc <= exp_bundle.pc;
                model_mcause <= 32'd11;
            end else begin
                if (wb.csr_wen[0]) model_mepc <= wb.csr_value;
                if (wb.csr_wen[1]) model_mcause <= wb.csr_value;
            end
            if (wb.csr_wen[2]) model_mstatus <= wb.csr_value;
            if (wb.csr_wen[3]) model_mtvec <= wb.csr_value;
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            exp_pc <= reset_pc;
            transfers <= 0;
            pushes <= 0;
        end else begin
            if (transfer) begin
                exp_pc <= exp_pc + 32'd4;
                transfers <= transfers + 1;
            end
            if (imem_req) pushes <= pushes + 1;
        end
        last_bundle <= out_bundle;
        last_stall <= !reset && out_valid && !out_ready;
    end

    always @(posedge clock) begin
        ready_roll = $urandom;
        if (reset) out_ready <= 1'b0;
        else out_ready <= (ready_roll % 32'd10) < 32'd6;  // about 60 percent
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the transfers did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    a_order: assert property (@(posedge clock) disable iff (reset)
        transfer |-> out_bundle.pc == exp_pc)
        else report_mismatch("order", 128'($sampled(exp_pc)), 128'($sampled(out_bundle.pc)));

    a_stable: assert property (@(posedge clock) disable iff (reset)
        last_stall |-> out_valid && out_bundle == last_bundle)
        else report_mismatch("stable", 128'($sampled(last_bundle.pc)),
                             128'($sampled(out_bundle.pc)));

    a_fields: assert property (@(posedge clock) disable iff (reset)
        transfer |-> {out_bundle.imm, out_bundle.rd, out_bundle.funct3} ==
                     {exp_bundle.imm, exp_bundle.rd, exp_bundle.funct3})
        else report_mismatch("fields",
            128'($sampled({exp_bundle.imm, exp_bundle.rd, exp_bundle.funct3})),
            128'($sampled({out_bundle.imm, out_bundle.rd, out_bundle.funct3})));

    a_control: assert property (@(posedge clock) disable iff (reset)
        transfer |-> control_bits(out_bundle) == control_bits(exp_bundle))
        else report_mismatch("control", 128'(control_bits($sampled(exp_bundle))),
                             128'(control_bits($sampled(out_bundle))));

    a_link: assert property (@(posedge clock) disable iff (reset)
        transfer |-> out_bundle.link_value == exp_bundle.link_value)
        else report_mismatch("link", 128'($sampled(exp_bundle.link_value)),
                             128'($sampled(out_bundle.link_value)));

    a_operands: assert property (@(posedge clock) disable iff (reset)
        transfer |-> {out_bundle.rs1_value, out_bundle.rs2_value} ==
                     {exp_bundle.rs1_value, exp_bundle.rs2_value})
        else report_mismatch("operands",
            128'($sampled({exp_bundle.rs1_value, exp_bundle.rs2_value})),
            128'($sampled({out_bundle.rs1_value, out_bundle.rs2_value})));

    a_ecall_mepc: assert property (@(posedge clock) disable iff (reset)
        (transfer && exp_bundle.ecall) |-> mepc_out == exp_bundle.pc)
        else report_mismatch("ecall_mepc", 128'($sampled(exp_bundle.pc)),
                             128'($sampled(mepc_out)));

    a_mtvec: assert property (@(posedge clock) disable iff (reset)
        mtvec_out == model_mtvec)
        else report_mismatch("mtvec", 128'($sampled(model_mtvec)), 128'($sampled(mtvec_out)));

    initial begin
        int          i;
        logic [31:0] r;
        r = $urandom(32'h8b1a);
        reset = 1'b1;
        fetch_enable = 1'b0;
        wb = '0;
        for (i = 0; i < nr_regs; i++) model_regs[i] = '0;
        branch_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd1};
        csr_pick = '{csr_mepc, csr_mcause, csr_mstatus, csr_mtvec,
                     12'h7c0, csr_mtvec, csr_mstatus, 12'h001};
        for (i = 0; i < nr_words; i++) begin
            r = $urandom;
            case (i % 16)
                0: imem[i] = {r[31:7], op_lui};
                1: imem[i] = {r[31:7], op_auipc};
                2: imem[i] = {r[31:7], op_jal};
                3: imem[i] = {r[31:15], 3'b000, r[11:7], op_jalr};
                4: imem[i] = {r[31:15], branch_f3[r[14:12]], r[11:7], op_branch};
                5: imem[i] = {r[31:7], op_load};
                6: imem[i] = {r[31:7], op_store};
                7: imem[i] = {r[31:7], op_imm};
                8: imem[i] = {1'b0, r[30], 5'b00000, r[24:7], op_reg};
                9: imem[i] = {csr_pick[r[2:0]], r[19:15], 3'b001, r[11:7], op_system};
                10: imem[i] = {csr_pick[r[5:3]], r[19:15], 3'b010, r[11:7], op_system};
                11: imem[i] = 32'h0000_0073;  // ecall
                12: imem[i] = 32'h3020_0073;  // mret
                13: imem[i] = 32'h0000_100f;  // fence.i
                14: imem[i] = {r[31:15], 3'b000, r[11:7], op_fence};
                default: imem[i] = {csr_mtvec, r[19:15], 3'b010, r[11:7], op_system};
            endcase
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (i = 1; i < nr_regs; i++) write_reg(4'(i), $urandom);
        write_csr(4'b1000, $urandom);
        write_csr(4'b0100, $urandom);
        @(posedge clock);
        wb <= '0;
        fetch_enable <= 1'b1;
        while (transfers < nr_transfers / 2) @(posedge clock);
        fetch_enable <= 1'b0;  // drain, then write back while idle
        @(posedge clock);
        while (transfers != pushes) @(posedge clock);
        r = $urandom;
        write_reg(r[3:0], $urandom);
        write_reg(r[7:4], $urandom);
        write_csr(4'b1000, $urandom);
        @(posedge clock);
        wb <= '0;
        fetch_enable <= 1'b1;
        while (transfers < nr_transfers) @(posedge clock);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/rv_pkg.sv
verilog/fetch_unit.sv
verilog/inst_queue.sv
verilog/reg_file.sv
verilog/decode_unit.sv
verilog/decode_core.sv
tb/tb_clock.sv
tb/decode_chk.sv
tb/decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := decode_tb
FILELIST  := vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
